// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

  // **********************************************************************
  // response codes
  // **********************************************************************

  localparam logic [1:0] axi_resp_okay = 2'b00;  // only response ever given

  // **********************************************************************
  // bus width defaults
  // **********************************************************************

  localparam int axi_data_width_default = 32;
  localparam int axi_addr_width_default = 16;  // byte address

  // lowest address bit that selects a word, below it are byte lanes
  function automatic int word_lsb(input int data_width);
    return $clog2(data_width / 8);
  endfunction

endpackage

// ==== source/pulse_ctl_pkg.sv ====
package pulse_ctl_pkg;

  // **********************************************************************
  // control bank, written by the host
  // **********************************************************************

  localparam int ctl_words = 4;

  localparam int ctl_word_control = 0;  // enable and clear bits
  localparam int ctl_word_period  = 1;  // cycles per pulse period
  localparam int ctl_word_high    = 2;  // high cycles per period
  localparam int ctl_word_limit   = 3;  // pulse count limit, 0 = free run

  localparam int ctl_bit_enable = 0;
  localparam int ctl_bit_clear  = 1;  // holds count, phase and done at zero

  // **********************************************************************
  // status bank, read by the host
  // **********************************************************************

  localparam int sts_words = 2;

  localparam int sts_word_count = 0;  // pulses started so far
  localparam int sts_word_flags = 1;

  localparam int sts_bit_running = 0;
  localparam int sts_bit_done    = 1;  // limit reached, sticky until clear

endpackage

// ==== source/axi_ctl_register.sv ====
module axi_ctl_register
  import axi_lite_pkg::*;
#(
  parameter int ctl_data_width = 128,
  parameter int axi_data_width = 32,
  parameter int axi_addr_width = 16
) (
  input  logic                        aclk,
  input  logic                        aresetn,
  output logic [ctl_data_width-1:0]   ctl_data,
  input  logic [axi_addr_width-1:0]   s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [axi_data_width-1:0]   s_axi_wdata,
  input  logic [axi_data_width/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  input  logic [axi_addr_width-1:0]   s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [axi_data_width-1:0]   s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready
);

  localparam int addr_lsb = word_lsb(axi_data_width);
  localparam int ctl_size = ctl_data_width / axi_data_width;
  localparam int strb_width = axi_data_width / 8;

  logic [ctl_data_width-1:0] bank_q;

  // **********************************************************************
  // write path
  // **********************************************************************

  logic                      aw_hold;
  logic                      w_hold;
  logic                      bvalid_q;
  logic [axi_addr_width-1:0] awaddr_q;
  logic [axi_data_width-1:0] wdata_q;
  logic [strb_width-1:0]     wstrb_q;
  logic [axi_addr_width-1:0] wr_index;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      wr_commit;

  assign s_axi_awready = ~aw_hold;
  assign s_axi_wready  = ~w_hold;
  assign aw_fire   = s_axi_awvalid & s_axi_awready;
  assign w_fire    = s_axi_wvalid & s_axi_wready;
  assign wr_commit = aw_hold & w_hold & ~bvalid_q;  // waits for previous response
  assign wr_index  = awaddr_q >> addr_lsb;

  always_ff @(posedge aclk) begin
    if (aw_fire) awaddr_q <= s_axi_awaddr;
    if (w_fire) begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      aw_hold  <= 1'b0;
      w_hold   <= 1'b0;
      bvalid_q <= 1'b0;
      bank_q   <= '0;
    end else begin
      if (aw_fire) aw_hold <= 1'b1;
      if (w_fire) w_hold <= 1'b1;
      if (wr_commit) begin
        for (int w = 0; w < ctl_size; w++) begin
          if (wr_index == axi_addr_width'(w)) begin
            for (int b = 0; b < strb_width; b++) begin
              if (wstrb_q[b]) bank_q[w*axi_data_width + b*8 +: 8] <= wdata_q[b*8 +: 8];
            end
          end
        end
        aw_hold  <= 1'b0;
        w_hold   <= 1'b0;
        bvalid_q <= 1'b1;  // out of range index still answers
      end
      if (bvalid_q && s_axi_bready) bvalid_q <= 1'b0;
    end
  end

  assign s_axi_bvalid = bvalid_q;
  assign s_axi_bresp  = axi_resp_okay;
  assign ctl_data     = bank_q;

  // **********************************************************************
  // read path
  // **********************************************************************

  logic                      ar_hold;
  logic                      rvalid_q;
  logic [axi_addr_width-1:0] araddr_q;
  logic [axi_data_width-1:0] rdata_q;
  logic [axi_addr_width-1:0] rd_index;
  logic [axi_data_width-1:0] rd_word;

  assign s_axi_arready = ~ar_hold & ~rvalid_q;
  assign rd_index = araddr_q >> addr_lsb;

  always_comb begin
    rd_word = '0;  // zero when out of range
    for (int w = 0; w < ctl_size; w++) begin
      if (rd_index == axi_addr_width'(w)) rd_word = bank_q[w*axi_data_width +: axi_data_width];
    end
  end

  always_ff @(posedge aclk) begin
    if (s_axi_arvalid && s_axi_arready) araddr_q <= s_axi_araddr;
    if (ar_hold && !rvalid_q) rdata_q <= rd_word;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_hold  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (s_axi_arvalid && s_axi_arready) ar_hold <= 1'b1;
      if (ar_hold && !rvalid_q) begin
        ar_hold  <= 1'b0;
        rvalid_q <= 1'b1;
      end else if (rvalid_q && s_axi_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign s_axi_rvalid = rvalid_q;
  assign s_axi_rdata  = rdata_q;
  assign s_axi_rresp  = axi_resp_okay;

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  a_rdata_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// ==== source/pulse_generator.sv ====
module pulse_generator
  import pulse_ctl_pkg::*;
#(
  parameter int axi_data_width = 32,
  parameter int axi_addr_width = 16,
  parameter int ctl_data_width = 128,
  parameter int sts_data_width = 64
) (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic [ctl_data_width-1:0] ctl_data,
  output logic [sts_data_width-1:0] sts_data,
  output logic                      pulse_out
);

  localparam int w = axi_data_width;

  // both banks must be reachable from the bus
  if (ctl_data_width / 8 > 2 ** axi_addr_width) begin : g_addr_check
    $error("control bank larger than the address space");
  end

  logic [w-1:0] control_w;
  logic [w-1:0] period_w;
  logic [w-1:0] high_w;
  logic [w-1:0] limit_w;
  logic         enable;
  logic         clear;
  logic         run;

  logic [w-1:0] phase_q;
  logic [w-1:0] count_q;
  logic         done_q;
  logic         running_q;
  logic         pulse_q;

  assign control_w = ctl_data[ctl_word_control*w +: w];
  assign period_w  = ctl_data[ctl_word_period*w +: w];
  assign high_w    = ctl_data[ctl_word_high*w +: w];
  assign limit_w   = ctl_data[ctl_word_limit*w +: w];
  assign enable    = control_w[ctl_bit_enable];
  assign clear     = control_w[ctl_bit_clear];
  assign run       = enable & ~clear & (period_w != '0) & ~done_q;

  always_ff @(posedge aclk) begin
    if (!aresetn || clear) begin
      phase_q   <= '0;
      count_q   <= '0;
      done_q    <= 1'b0;
      running_q <= 1'b0;
      pulse_q   <= 1'b0;
    end else begin
      running_q <= run;
      pulse_q   <= 1'b0;
      if (run) begin
        if (phase_q == '0 && limit_w != '0 && count_q >= limit_w) begin
          done_q    <= 1'b1;  // last period finished
          running_q <= 1'b0;
        end else begin
          pulse_q <= phase_q < high_w;
          if (phase_q == '0) count_q <= count_q + 1'b1;
          phase_q <= (phase_q >= period_w - 1'b1) ? '0 : phase_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    sts_data = '0;
    sts_data[sts_word_count*w +: w] = count_q;
    sts_data[sts_word_flags*w + sts_bit_running] = running_q;
    sts_data[sts_word_flags*w + sts_bit_done] = done_q;
  end

  assign pulse_out = pulse_q;

  // a new count value never passes a set limit
  a_count_limit: assert property (@(posedge aclk) disable iff (!aresetn)
    limit_w != '0 && count_q != $past(count_q) |-> count_q <= limit_w);

endmodule

// ==== source/axi_sts_register.sv ====
module axi_sts_register
  import axi_lite_pkg::*;
#(
  parameter int sts_data_width = 64,
  parameter int axi_data_width = 32,
  parameter int axi_addr_width = 16
) (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic [sts_data_width-1:0] sts_data,
  input  logic [axi_addr_width-1:0] s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  output logic [axi_data_width-1:0] s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready
);

  localparam int addr_lsb = word_lsb(axi_data_width);
  localparam int sts_size = sts_data_width / axi_data_width;

  logic                      ar_hold;
  logic                      rvalid_q;
  logic [axi_addr_width-1:0] araddr_q;
  logic [axi_data_width-1:0] rdata_q;
  logic [axi_addr_width-1:0] rd_index;
  logic [axi_data_width-1:0] rd_word;
  logic                      ar_fire;

  assign s_axi_arready = ~ar_hold & ~rvalid_q;  // one read in flight
  assign ar_fire  = s_axi_arvalid & s_axi_arready;
  assign rd_index = araddr_q >> addr_lsb;

  // **********************************************************************
  // word select
  // **********************************************************************

  always_comb begin
    rd_word = '0;
    for (int w = 0; w < sts_size; w++) begin
      if (rd_index == axi_addr_width'(w)) begin
        rd_word = sts_data[w*axi_data_width +: axi_data_width];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_fire) araddr_q <= s_axi_araddr;
    if (ar_hold && !rvalid_q) rdata_q <= rd_word;  // status snapshot
  end

  // **********************************************************************
  // read handshake
  // **********************************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_hold  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (ar_fire) ar_hold <= 1'b1;
      if (ar_hold && !rvalid_q) begin
        ar_hold  <= 1'b0;
        rvalid_q <= 1'b1;
      end else if (rvalid_q && s_axi_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign s_axi_rvalid = rvalid_q;
  assign s_axi_rdata  = rdata_q;
  assign s_axi_rresp  = axi_resp_okay;

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

endmodule

// ==== source/pulse_gen_system.sv ====
module pulse_gen_system
  import axi_lite_pkg::*;
  import pulse_ctl_pkg::*;
#(
  parameter int axi_data_width = axi_data_width_default,
  parameter int axi_addr_width = axi_addr_width_default
) (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic [axi_addr_width-1:0]   s_ctl_axi_awaddr,
  input  logic                        s_ctl_axi_awvalid,
  output logic                        s_ctl_axi_awready,
  input  logic [axi_data_width-1:0]   s_ctl_axi_wdata,
  input  logic [axi_data_width/8-1:0] s_ctl_axi_wstrb,
  input  logic                        s_ctl_axi_wvalid,
  output logic                        s_ctl_axi_wready,
  output logic [1:0]                  s_ctl_axi_bresp,
  output logic                        s_ctl_axi_bvalid,
  input  logic                        s_ctl_axi_bready,
  input  logic [axi_addr_width-1:0]   s_ctl_axi_araddr,
  input  logic                        s_ctl_axi_arvalid,
  output logic                        s_ctl_axi_arready,
  output logic [axi_data_width-1:0]   s_ctl_axi_rdata,
  output logic [1:0]                  s_ctl_axi_rresp,
  output logic                        s_ctl_axi_rvalid,
  input  logic                        s_ctl_axi_rready,
  input  logic [axi_addr_width-1:0]   s_sts_axi_araddr,
  input  logic                        s_sts_axi_arvalid,
  output logic                        s_sts_axi_arready,
  output logic [axi_data_width-1:0]   s_sts_axi_rdata,
  output logic [1:0]                  s_sts_axi_rresp,
  output logic                        s_sts_axi_rvalid,
  input  logic                        s_sts_axi_rready,
  output logic                        pulse_out
);

  localparam int ctl_data_width = ctl_words * axi_data_width;
  localparam int sts_data_width = sts_words * axi_data_width;

  logic [ctl_data_width-1:0] ctl_data;
  logic [sts_data_width-1:0] sts_data;

  axi_ctl_register #(
    .ctl_data_width(ctl_data_width),
    .axi_data_width(axi_data_width),
    .axi_addr_width(axi_addr_width)
  ) ctl_reg_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .ctl_data      (ctl_data),
    .s_axi_awaddr  (s_ctl_axi_awaddr),
    .s_axi_awvalid (s_ctl_axi_awvalid),
    .s_axi_awready (s_ctl_axi_awready),
    .s_axi_wdata   (s_ctl_axi_wdata),
    .s_axi_wstrb   (s_ctl_axi_wstrb),
    .s_axi_wvalid  (s_ctl_axi_wvalid),
    .s_axi_wready  (s_ctl_axi_wready),
    .s_axi_bresp   (s_ctl_axi_bresp),
    .s_axi_bvalid  (s_ctl_axi_bvalid),
    .s_axi_bready  (s_ctl_axi_bready),
    .s_axi_araddr  (s_ctl_axi_araddr),
    .s_axi_arvalid (s_ctl_axi_arvalid),
    .s_axi_arready (s_ctl_axi_arready),
    .s_axi_rdata   (s_ctl_axi_rdata),
    .s_axi_rresp   (s_ctl_axi_rresp),
    .s_axi_rvalid  (s_ctl_axi_rvalid),
    .s_axi_rready  (s_ctl_axi_rready)
  );

  pulse_generator #(
    .axi_data_width(axi_data_width),
    .axi_addr_width(axi_addr_width),
    .ctl_data_width(ctl_data_width),
    .sts_data_width(sts_data_width)
  ) pulse_gen_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .ctl_data  (ctl_data),
    .sts_data  (sts_data),
    .pulse_out (pulse_out)
  );

  axi_sts_register #(
    .sts_data_width(sts_data_width),
    .axi_data_width(axi_data_width),
    .axi_addr_width(axi_addr_width)
  ) sts_reg_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .sts_data      (sts_data),
    .s_axi_araddr  (s_sts_axi_araddr),
    .s_axi_arvalid (s_sts_axi_arvalid),
    .s_axi_arready (s_sts_axi_arready),
    .s_axi_rdata   (s_sts_axi_rdata),
    .s_axi_rresp   (s_sts_axi_rresp),
    .s_axi_rvalid  (s_sts_axi_rvalid),
    .s_axi_rready  (s_sts_axi_rready)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 2
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(period / 2) aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;  // released away from the active edge
  end

endmodule

// ==== dv/pulse_gen_system_tb.sv ====
module pulse_gen_system_tb
  import axi_lite_pkg::*;
  import pulse_ctl_pkg::*;
();

  localparam int data_width   = axi_data_width_default;
  localparam int addr_width   = axi_addr_width_default;
  localparam int strb_width   = data_width / 8;
  localparam int rand_writes  = 24;
  localparam int op_cycles    = 16;  // one transfer with the longest stall
  localparam int pulse_cycles = 9 * 4 + 4;  // longest period times largest limit
  localparam int timeout_cycles =
    2 * (op_cycles * (8 + 2 * rand_writes + 10 + 12 + 10 + 8) + 2 * pulse_cycles);

  logic aclk, aresetn, pulse_out;
  logic [addr_width-1:0] ctl_awaddr, ctl_araddr, sts_araddr;
  logic [data_width-1:0] ctl_wdata, ctl_rdata, sts_rdata;
  logic [strb_width-1:0] ctl_wstrb;
  logic [1:0]            ctl_bresp, ctl_rresp, sts_rresp;
  logic ctl_awvalid, ctl_awready, ctl_wvalid, ctl_wready, ctl_bvalid, ctl_bready;
  logic ctl_arvalid, ctl_arready, ctl_rvalid, ctl_rready;
  logic sts_arvalid, sts_arready, sts_rvalid, sts_rready;

  logic [data_width-1:0] model_bank [ctl_words];  // expected control bank
  logic [31:0] seed;
  string       test_name = "startup";
  int errors = 0, errors_at_start = 0, tests_run = 0, tests_failed = 0;
  int cycles = 0, rises = 0, highs = 0;
  logic pulse_prev = 1'b0;
  int period, high_time, limit;

  tb_clock_gen #(.period(4), .reset_cycles(2)) clk_gen_i (.aclk(aclk), .aresetn(aresetn));

  pulse_gen_system #(
    .axi_data_width(data_width),
    .axi_addr_width(addr_width)
  ) dut_i (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .s_ctl_axi_awaddr  (ctl_awaddr),
    .s_ctl_axi_awvalid (ctl_awvalid),
    .s_ctl_axi_awready (ctl_awready),
    .s_ctl_axi_wdata   (ctl_wdata),
    .s_ctl_axi_wstrb   (ctl_wstrb),
    .s_ctl_axi_wvalid  (ctl_wvalid),
    .s_ctl_axi_wready  (ctl_wready),
    .s_ctl_axi_bresp   (ctl_bresp),
    .s_ctl_axi_bvalid  (ctl_bvalid),
    .s_ctl_axi_bready  (ctl_bready),
    .s_ctl_axi_araddr  (ctl_araddr),
    .s_ctl_axi_arvalid (ctl_arvalid),
    .s_ctl_axi_arready (ctl_arready),
    .s_ctl_axi_rdata   (ctl_rdata),
    .s_ctl_axi_rresp   (ctl_rresp),
    .s_ctl_axi_rvalid  (ctl_rvalid),
    .s_ctl_axi_rready  (ctl_rready),
    .s_sts_axi_araddr  (sts_araddr),
    .s_sts_axi_arvalid (sts_arvalid),
    .s_sts_axi_arready (sts_arready),
    .s_sts_axi_rdata   (sts_rdata),
    .s_sts_axi_rresp   (sts_rresp),
    .s_sts_axi_rvalid  (sts_rvalid),
    .s_sts_axi_rready  (sts_rready),
    .pulse_out         (pulse_out)
  );

  // **********************************************************************
  // protocol checks and pulse monitor
  // **********************************************************************

  a_ctl_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ctl_bvalid && !ctl_bready |=> ctl_bvalid && $stable(ctl_bresp))
    else begin
      errors++;
      $display("write response dropped or changed before bready in test %s", test_name);
    end

  a_ctl_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ctl_rvalid && !ctl_rready |=> ctl_rvalid && $stable(ctl_rdata))
    else begin
      errors++;
      $display("control read data dropped or changed before rready in test %s", test_name);
    end

  a_sts_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    sts_rvalid && !sts_rready |=> sts_rvalid && $stable(sts_rdata))
    else begin
      errors++;
      $display("status read data dropped or changed before rready in test %s", test_name);
    end

  always @(negedge aclk) begin
    if (pulse_out && !pulse_prev) rises++;
    if (pulse_out) highs++;
    pulse_prev = pulse_out;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, test %s did not finish", cycles, test_name);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // **********************************************************************
  // helpers
  // **********************************************************************

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((next_rand() >> 8) % (hi - lo + 1));  // upper bits vary more
  endfunction

  function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old,
      input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
    logic [data_width-1:0] res;
    res = old;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic expect_equal(input string what, input logic [data_width-1:0] exp,
      input logic [data_width-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s passed", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s failed with %0d errors", tests_run, test_name,
               errors - errors_at_start);
    end
  endtask

  // address and data may be accepted on different cycles
  task automatic write_beats(input int index, input logic [data_width-1:0] data,
      input logic [strb_width-1:0] strb);
    logic aw_go, w_go;
    ctl_awaddr  = addr_width'(index * strb_width);
    ctl_wdata   = data;
    ctl_wstrb   = strb;
    ctl_awvalid = 1'b1;
    ctl_wvalid  = 1'b1;
    while (ctl_awvalid || ctl_wvalid) begin
      aw_go = ctl_awready;
      w_go  = ctl_wready;
      @(negedge aclk);
      if (aw_go) ctl_awvalid = 1'b0;
      if (w_go) ctl_wvalid = 1'b0;
    end
  endtask

  task automatic write_resp(input int delay);
    ctl_bready = 1'b0;
    while (!ctl_bvalid) @(negedge aclk);
    repeat (delay) @(negedge aclk);
    expect_equal("bresp", data_width'(axi_resp_okay), data_width'(ctl_bresp));
    ctl_bready = 1'b1;
    @(negedge aclk);
    ctl_bready = 1'b0;
  endtask

  task automatic write_word(input int index, input logic [data_width-1:0] data,
      input logic [strb_width-1:0] strb);
    write_beats(index, data, strb);
    write_resp(rand_range(0, 3));
    if (index < ctl_words) model_bank[index] = merge_bytes(model_bank[index], data, strb);
  endtask

  task automatic ctl_read(input int index, input int delay, output logic [data_width-1:0] data);
    ctl_araddr  = addr_width'(index * strb_width);
    ctl_arvalid = 1'b1;
    while (!ctl_arready) @(negedge aclk);
    @(negedge aclk);
    ctl_arvalid = 1'b0;
    while (!ctl_rvalid) @(negedge aclk);
    repeat (delay) @(negedge aclk);
    data = ctl_rdata;
    expect_equal("ctl rresp", data_width'(axi_resp_okay), data_width'(ctl_rresp));
    ctl_rready = 1'b1;
    @(negedge aclk);
    ctl_rready = 1'b0;
  endtask

  task automatic sts_read(input int index, input int delay, output logic [data_width-1:0] data);
    sts_araddr  = addr_width'(index * strb_width);
    sts_arvalid = 1'b1;
    while (!sts_arready) @(negedge aclk);
    @(negedge aclk);
    sts_arvalid = 1'b0;
    while (!sts_rvalid) @(negedge aclk);
    repeat (delay) @(negedge aclk);
    data = sts_rdata;
    expect_equal("sts rresp", data_width'(axi_resp_okay), data_width'(sts_rresp));
    sts_rready = 1'b1;
    @(negedge aclk);
    sts_rready = 1'b0;
  endtask

  task automatic check_word(input int index);
    logic [data_width-1:0] rd;
    ctl_read(index, rand_range(0, 3), rd);
    expect_equal($sformatf("word %0d", index), index < ctl_words ? model_bank[index] : '0, rd);
  endtask

  task automatic check_status(input int index, input logic [data_width-1:0] exp);
    logic [data_width-1:0] rd;
    sts_read(index, rand_range(0, 3), rd);
    expect_equal($sformatf("status word %0d", index), exp, rd);
  endtask

  task automatic wait_done();
    logic [data_width-1:0] flags;
    flags = '0;
    while (!flags[sts_bit_done]) sts_read(sts_word_flags, 0, flags);
  endtask

  // **********************************************************************
  // tests
  // **********************************************************************

  initial begin
    logic [data_width-1:0] rd, a_word, b_word;
    int idx, r0, h0;
    seed = 32'd89530;
    {ctl_awaddr, ctl_araddr, sts_araddr, ctl_wdata, ctl_wstrb} = '0;
    {ctl_awvalid, ctl_wvalid, ctl_bready, ctl_arvalid, ctl_rready} = '0;
    {sts_arvalid, sts_rready} = '0;
    for (int i = 0; i < ctl_words; i++) model_bank[i] = '0;
    @(posedge aresetn);
    @(negedge aclk);

    start_test("reset");
    expect_equal("ready and valid outputs", data_width'(8'b1111_0000), data_width'({ctl_awready,
                 ctl_wready, ctl_arready, sts_arready, ctl_bvalid, ctl_rvalid, sts_rvalid,
                 pulse_out}));
    for (int i = 0; i < ctl_words; i++) check_word(i);
    end_test();

    start_test("strobe_writes");
    for (int i = 0; i < rand_writes; i++) begin
      idx = rand_range(0, ctl_words - 1);
      write_word(idx, next_rand(), strb_width'(rand_range(0, 2 ** strb_width - 1)));
      check_word(idx);
    end
    end_test();

    start_test("out_of_range");
    for (int i = 0; i < 3; i++) begin
      idx = ctl_words + rand_range(0, 11);
      write_word(idx, next_rand(), '1);
      check_word(idx);
    end
    for (int i = 0; i < ctl_words; i++) check_word(i);
    check_status(sts_words + rand_range(0, 5), '0);
    end_test();

    start_test("pulse_limit");
    period    = rand_range(2, 9);
    high_time = rand_range(1, period - 1);
    limit     = rand_range(1, 4);
    write_word(ctl_word_control, data_width'(1 << ctl_bit_clear), '1);
    write_word(ctl_word_period, data_width'(period), '1);
    write_word(ctl_word_high, data_width'(high_time), '1);
    write_word(ctl_word_limit, data_width'(limit), '1);
    r0 = rises;
    h0 = highs;
    write_word(ctl_word_control, data_width'(1 << ctl_bit_enable), '1);  // enable last
    wait_done();
    check_status(sts_word_count, data_width'(limit));
    check_status(sts_word_flags, data_width'(1 << sts_bit_done));
    expect_equal("rising edges", data_width'(limit), data_width'(rises - r0));
    expect_equal("high cycles", data_width'(limit * high_time), data_width'(highs - h0));
    end_test();

    start_test("clear_restart");
    write_word(ctl_word_control, data_width'((1 << ctl_bit_enable) | (1 << ctl_bit_clear)), '1);
    check_status(sts_word_count, '0);
    check_status(sts_word_flags, '0);
    r0 = rises;
    write_word(ctl_word_control, data_width'(1 << ctl_bit_enable), '1);
    wait_done();
    check_status(sts_word_count, data_width'(limit));
    expect_equal("rising edges", data_width'(limit), data_width'(rises - r0));
    end_test();

    start_test("back_pressure");
    a_word = next_rand();
    b_word = next_rand();
    write_beats(ctl_word_high, a_word, '1);
    while (!ctl_bvalid) @(negedge aclk);
    write_beats(ctl_word_high, b_word, '1);  // second write parks behind bvalid
    ctl_read(ctl_word_high, rand_range(2, 6), rd);
    expect_equal("first write", a_word, rd);
    write_resp(rand_range(1, 4));
    model_bank[ctl_word_high] = a_word;
    write_resp(0);
    model_bank[ctl_word_high] = b_word;
    check_word(ctl_word_high);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/axi_lite_pkg.sv
source/pulse_ctl_pkg.sv
source/axi_ctl_register.sv
source/pulse_generator.sv
source/axi_sts_register.sv
source/pulse_gen_system.sv
dv/tb_clock_gen.sv
dv/pulse_gen_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pulse generator testbench with Verilator.
# The log is searched for the pass line; anything else is a failure.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
    --top-module pulse_gen_system_tb \
    -f compile.f -o pulse_gen_sim \
  && ./obj_dir/pulse_gen_sim | tee sim.log \
  && grep -q "^Simulation finished: PASS$" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }
